// File: logic/imuldiv_pkg.sv
/*
 * shared types for the iterative multiply/divide unit
 * function codes and iteration control states
 */

package imuldiv_pkg;

  // ----------------------------------------------------------
  // request function codes
  // ----------------------------------------------------------

  // mul gives the full signed product
  // div and divu give {remainder, quotient}
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } imuldiv_fn_e;

  // ----------------------------------------------------------
  // iterative control states
  // ----------------------------------------------------------

  // idle waits for a request, calc runs the iterations,
  // done holds the response until it is taken
  typedef enum logic [1:0] {
    idle = 2'd0,
    calc = 2'd1,
    done = 2'd2
  } iter_state_e;

endpackage

// File: logic/imuldiv_iter_if.sv
/*
 * register-enable and mux-select strobes from an iterative control to its datapath
 */

`timescale 1ns/1ps

interface imuldiv_iter_if;

  // en with sel low loads operands, en with sel high iterates
  logic a_en;
  logic a_mux_sel;
  logic b_en;
  logic b_mux_sel;

  modport ctrl (
    output a_en, a_mux_sel, b_en, b_mux_sel
  );

  modport dpath (
    input a_en, a_mux_sel, b_en, b_mux_sel
  );

endinterface

// File: logic/imuldiv_mul_iterative.sv
/*
 * iterative signed multiplier, shift-and-add on operand magnitudes
 * unit wrapper, datapath and control
 */

`timescale 1ns/1ps

module imuldiv_mul_iterative import imuldiv_pkg::*; #(
  parameter int W = 32
) (
  input  logic           clk,
  input  logic           reset,
  input  logic [W-1:0]   a,
  input  logic [W-1:0]   b,
  input  logic           req_val,
  output logic           req_rdy,
  output logic [2*W-1:0] resp_result,
  output logic           resp_val,
  input  logic           resp_rdy
);

  // strobes from control to datapath
  imuldiv_iter_if iter ();

  imuldiv_mul_dpath #(.W(W)) dpath (
    .clk         (clk),
    .reset       (reset),
    .a           (a),
    .b           (b),
    .resp_result (resp_result),
    .ctl         (iter)
  );

  imuldiv_mul_ctrl #(.W(W)) ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .ctl      (iter)
  );

endmodule

// ------------------------------------------------------------
// datapath
// ------------------------------------------------------------

module imuldiv_mul_dpath import imuldiv_pkg::*; #(
  parameter int W = 32
) (
  input  logic           clk,
  input  logic           reset,
  input  logic [W-1:0]   a,
  input  logic [W-1:0]   b,
  output logic [2*W-1:0] resp_result,
  imuldiv_iter_if.dpath  ctl
);

  logic           sign_a;
  logic           sign_b;
  logic [W-1:0]   mag_a;
  logic [W-1:0]   mag_b;
  logic           load;
  logic           step;

  // multiplicand grows left into the upper half
  logic [2*W-1:0] a_reg;
  logic [W-1:0]   b_reg;
  logic [2*W-1:0] acc_reg;
  logic           sign_a_reg;
  logic           sign_b_reg;

  // operand signs and magnitudes straight off the request
  assign sign_a = a[W-1];
  assign sign_b = b[W-1];
  assign mag_a  = sign_a ? (~a + 1'b1) : a;
  assign mag_b  = sign_b ? (~b + 1'b1) : b;

  assign load = ctl.a_en & ~ctl.a_mux_sel;
  assign step = ctl.a_en & ctl.a_mux_sel;

  // operand shift registers
  always_ff @(posedge clk) begin
    if (ctl.a_en) begin
      a_reg <= ctl.a_mux_sel ? (a_reg << 1) : {{W{1'b0}}, mag_a};
    end
    if (ctl.b_en) begin
      b_reg <= ctl.b_mux_sel ? (b_reg >> 1) : mag_b;
    end
  end

  // accumulator and latched signs
  always_ff @(posedge clk) begin
    if (reset) begin
      acc_reg    <= '0;
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
    end else if (load) begin
      acc_reg    <= '0;
      sign_a_reg <= sign_a;
      sign_b_reg <= sign_b;
    end else if (step && b_reg[0]) begin
      // add the shifted multiplicand for each set multiplier bit
      acc_reg <= acc_reg + a_reg;
    end
  end

  // sign fix when exactly one operand was negative
  assign resp_result = (sign_a_reg ^ sign_b_reg) ? (~acc_reg + 1'b1) : acc_reg;

endmodule

// ------------------------------------------------------------
// control
// ------------------------------------------------------------

module imuldiv_mul_ctrl import imuldiv_pkg::*; #(
  parameter int W = 32
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          req_val,
  output logic          req_rdy,
  output logic          resp_val,
  input  logic          resp_rdy,
  imuldiv_iter_if.ctrl  ctl
);

  localparam int CW = $clog2(W);

  iter_state_e   state;
  logic [CW-1:0] count;
  logic          req_go;
  logic          resp_go;

  assign req_go  = req_val & req_rdy;
  assign resp_go = resp_val & resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      count <= '0;
    end else begin
      case (state)
        idle: begin
          if (req_go) begin
            state <= calc;
            count <= '0;
          end
        end
        calc: begin
          // one multiplier bit per cycle
          if (count == CW'(W - 1)) begin
            state <= done;
          end else begin
            count <= count + 1'b1;
          end
        end
        done: begin
          if (resp_go) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_comb begin
    req_rdy       = 1'b0;
    resp_val      = 1'b0;
    ctl.a_en      = 1'b0;
    ctl.a_mux_sel = 1'b0;
    ctl.b_en      = 1'b0;
    ctl.b_mux_sel = 1'b0;
    case (state)
      idle: begin
        // acceptance edge loads magnitudes
        req_rdy  = 1'b1;
        ctl.a_en = req_go;
        ctl.b_en = req_go;
      end
      calc: begin
        ctl.a_en      = 1'b1;
        ctl.a_mux_sel = 1'b1;
        ctl.b_en      = 1'b1;
        ctl.b_mux_sel = 1'b1;
      end
      done: begin
        resp_val = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: logic/imuldiv_div_iterative.sv
/*
 * iterative restoring divider for signed and unsigned operands
 * unit wrapper, datapath and control
 */

`timescale 1ns/1ps

module imuldiv_div_iterative import imuldiv_pkg::*; #(
  parameter int W = 32
) (
  input  logic           clk,
  input  logic           reset,
  input  logic [W-1:0]   a,
  input  logic [W-1:0]   b,
  input  logic           is_signed,
  input  logic           req_val,
  output logic           req_rdy,
  output logic [2*W-1:0] resp_result,
  output logic           resp_val,
  input  logic           resp_rdy
);

  imuldiv_iter_if iter ();

  imuldiv_div_dpath #(.W(W)) dpath (
    .clk         (clk),
    .reset       (reset),
    .a           (a),
    .b           (b),
    .is_signed   (is_signed),
    .resp_result (resp_result),
    .ctl         (iter)
  );

  imuldiv_div_ctrl #(.W(W)) ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .ctl      (iter)
  );

endmodule

// ------------------------------------------------------------
// datapath
// ------------------------------------------------------------

module imuldiv_div_dpath import imuldiv_pkg::*; #(
  parameter int W = 32
) (
  input  logic           clk,
  input  logic           reset,
  input  logic [W-1:0]   a,
  input  logic [W-1:0]   b,
  input  logic           is_signed,
  output logic [2*W-1:0] resp_result,
  imuldiv_iter_if.dpath  ctl
);

  logic           sign_a;
  logic           sign_b;
  logic [W-1:0]   mag_a;
  logic [W-1:0]   mag_b;

  // remainder in the upper half, quotient bits enter from the right
  logic [2*W-1:0] rq_reg;
  logic [W-1:0]   dvs_reg;
  logic           sign_q_reg;
  logic           sign_r_reg;

  logic [W:0]     rem_shift;
  logic [W-1:0]   rem_sub;
  logic           fits;
  logic [2*W-1:0] rq_next;
  logic [W-1:0]   quo;
  logic [W-1:0]   rem;

  // divu keeps the operands as they are
  assign sign_a = is_signed & a[W-1];
  assign sign_b = is_signed & b[W-1];
  assign mag_a  = sign_a ? (~a + 1'b1) : a;
  assign mag_b  = sign_b ? (~b + 1'b1) : b;

  // ----------------------------------------------------------
  // one restoring step
  // ----------------------------------------------------------

  // partial remainder shifted left with the next dividend bit
  assign rem_shift = rq_reg[2*W-1:W-1];
  assign fits      = rem_shift >= {1'b0, dvs_reg};

  // difference is below the divisor so W bits hold it
  assign rem_sub = rem_shift[W-1:0] - dvs_reg;

  // zero divisor always fits, giving all-ones quotient
  assign rq_next = fits ? {rem_sub, rq_reg[W-2:0], 1'b1}
                        : {rem_shift[W-1:0], rq_reg[W-2:0], 1'b0};

  always_ff @(posedge clk) begin
    if (ctl.a_en) begin
      rq_reg <= ctl.a_mux_sel ? rq_next : {{W{1'b0}}, mag_a};
    end
    // divisor holds through the iterations
    if (ctl.b_en) begin
      dvs_reg <= ctl.b_mux_sel ? dvs_reg : mag_b;
    end
  end

  // result signs latched on the load strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      sign_q_reg <= 1'b0;
      sign_r_reg <= 1'b0;
    end else if (ctl.a_en && !ctl.a_mux_sel) begin
      sign_q_reg <= sign_a ^ sign_b;
      sign_r_reg <= sign_a;
    end
  end

  // ----------------------------------------------------------
  // output sign rules
  // ----------------------------------------------------------

  // quotient follows the sign xor, remainder follows the dividend
  assign quo = sign_q_reg ? (~rq_reg[W-1:0] + 1'b1) : rq_reg[W-1:0];
  assign rem = sign_r_reg ? (~rq_reg[2*W-1:W] + 1'b1) : rq_reg[2*W-1:W];

  assign resp_result = {rem, quo};

endmodule

// ------------------------------------------------------------
// control
// ------------------------------------------------------------

module imuldiv_div_ctrl import imuldiv_pkg::*; #(
  parameter int W = 32
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          req_val,
  output logic          req_rdy,
  output logic          resp_val,
  input  logic          resp_rdy,
  imuldiv_iter_if.ctrl  ctl
);

  localparam int CW = $clog2(W);

  iter_state_e   state;
  logic [CW-1:0] count;
  logic          req_go;
  logic          resp_go;
  logic          last_step;

  assign req_go    = req_val & req_rdy;
  assign resp_go   = resp_val & resp_rdy;
  assign last_step = (count == CW'(W - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      count <= '0;
    end else begin
      case (state)
        idle: begin
          if (req_go) begin
            state <= calc;
            count <= '0;
          end
        end
        calc: begin
          // one quotient bit per cycle, msb first
          count <= count + 1'b1;
          if (last_step) begin
            state <= done;
            count <= '0;
          end
        end
        done: begin
          if (resp_go) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_comb begin
    req_rdy       = 1'b0;
    resp_val      = 1'b0;
    ctl.a_en      = 1'b0;
    ctl.a_mux_sel = 1'b0;
    ctl.b_en      = 1'b0;
    ctl.b_mux_sel = 1'b0;
    case (state)
      idle: begin
        req_rdy  = 1'b1;
        ctl.a_en = req_go;
        ctl.b_en = req_go;
      end
      calc: begin
        // divisor iterates by selecting itself
        ctl.a_en      = 1'b1;
        ctl.a_mux_sel = 1'b1;
        ctl.b_en      = 1'b1;
        ctl.b_mux_sel = 1'b1;
      end
      done: begin
        resp_val = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: logic/imuldiv_dispatch.sv
/*
 * request routing by function code, single pending owner, response select
 */

`timescale 1ns/1ps

module imuldiv_dispatch import imuldiv_pkg::*; #(
  parameter int W = 32
) (
  input  logic           clk,
  input  logic           reset,
  input  imuldiv_fn_e    req_fn,
  input  logic           req_val,
  output logic           req_rdy,
  input  logic           resp_rdy,
  output logic           resp_val,
  output logic [2*W-1:0] resp_result,
  output logic           mul_req_val,
  input  logic           mul_req_rdy,
  output logic           div_req_val,
  input  logic           div_req_rdy,
  output logic           div_signed,
  input  logic           mul_resp_val,
  input  logic [2*W-1:0] mul_resp_result,
  output logic           mul_resp_rdy,
  input  logic           div_resp_val,
  input  logic [2*W-1:0] div_resp_result,
  output logic           div_resp_rdy
);

  logic busy;
  logic owner_div;
  logic sel_div;

  // any non-mul code goes to the divider
  assign sel_div    = (req_fn != fn_mul);
  assign div_signed = (req_fn == fn_div);

  // ------------------------------------------------------------
  // request side
  // ------------------------------------------------------------

  // nothing new while an operation is pending
  assign req_rdy     = ~busy & (sel_div ? div_req_rdy : mul_req_rdy);
  assign mul_req_val = req_val & ~busy & ~sel_div;
  assign div_req_val = req_val & ~busy & sel_div;

  // ------------------------------------------------------------
  // response side
  // ------------------------------------------------------------

  assign resp_val     = busy & (owner_div ? div_resp_val : mul_resp_val);
  assign resp_result  = owner_div ? div_resp_result : mul_resp_result;
  assign mul_resp_rdy = resp_rdy & busy & ~owner_div;
  assign div_resp_rdy = resp_rdy & busy & owner_div;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      owner_div <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy      <= 1'b1;
      owner_div <= sel_div;
    end else if (resp_val && resp_rdy) begin
      busy <= 1'b0;
    end
  end

endmodule

// File: logic/imuldiv_top.sv
/*
 * multiply/divide top level, dispatch plus the two iterative units
 */

`timescale 1ns/1ps

module imuldiv_top import imuldiv_pkg::*; #(
  parameter int W = 32
) (
  input  logic           clk,
  input  logic           reset,
  input  logic [W-1:0]   req_a,
  input  logic [W-1:0]   req_b,
  input  imuldiv_fn_e    req_fn,
  input  logic           req_val,
  output logic           req_rdy,
  output logic [2*W-1:0] resp_result,
  output logic           resp_val,
  input  logic           resp_rdy
);

  logic           mul_req_val;
  logic           mul_req_rdy;
  logic           mul_resp_val;
  logic           mul_resp_rdy;
  logic [2*W-1:0] mul_resp_result;

  logic           div_req_val;
  logic           div_req_rdy;
  logic           div_signed;
  logic           div_resp_val;
  logic           div_resp_rdy;
  logic [2*W-1:0] div_resp_result;

  imuldiv_dispatch #(.W(W)) dispatch (
    .clk             (clk),
    .reset           (reset),
    .req_fn          (req_fn),
    .req_val         (req_val),
    .req_rdy         (req_rdy),
    .resp_rdy        (resp_rdy),
    .resp_val        (resp_val),
    .resp_result     (resp_result),
    .mul_req_val     (mul_req_val),
    .mul_req_rdy     (mul_req_rdy),
    .div_req_val     (div_req_val),
    .div_req_rdy     (div_req_rdy),
    .div_signed      (div_signed),
    .mul_resp_val    (mul_resp_val),
    .mul_resp_result (mul_resp_result),
    .mul_resp_rdy    (mul_resp_rdy),
    .div_resp_val    (div_resp_val),
    .div_resp_result (div_resp_result),
    .div_resp_rdy    (div_resp_rdy)
  );

  // operands go to both units, only the selected one sees valid
  imuldiv_mul_iterative #(.W(W)) mul_unit (
    .clk         (clk),
    .reset       (reset),
    .a           (req_a),
    .b           (req_b),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .resp_result (mul_resp_result),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy)
  );

  imuldiv_div_iterative #(.W(W)) div_unit (
    .clk         (clk),
    .reset       (reset),
    .a           (req_a),
    .b           (req_b),
    .is_signed   (div_signed),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .resp_result (div_resp_result),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy)
  );

endmodule

// File: dv/imuldiv_asserts.sv
/*
 * handshake protocol assertions for the multiply/divide top level
 */

`timescale 1ns/1ps

module imuldiv_asserts #(
  parameter int W = 32
) (
  input logic           clk,
  input logic           reset,
  input logic           req_val,
  input logic           req_rdy,
  input logic           resp_val,
  input logic           resp_rdy,
  input logic [2*W-1:0] resp_result
);

  // set from the acceptance edge until the response transfers
  logic pending;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (req_val && req_rdy) begin
      pending <= 1'b1;
    end else if (resp_val && resp_rdy) begin
      pending <= 1'b0;
    end
  end

  // a stalled response keeps both valid and data
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)))
    else $error("response dropped or changed while stalled");

  // only one operation in flight
  req_blocked: assert property (@(posedge clk) disable iff (reset)
    pending |-> !req_rdy)
    else $error("request side ready while an operation is pending");

  // first cycle out of reset is idle
  reset_idle: assert property (@(posedge clk)
    $fell(reset) |-> (!resp_val && req_rdy))
    else $error("unit not idle after reset");

endmodule

bind imuldiv_top imuldiv_asserts #(.W(W)) protocol_checks (
  .clk         (clk),
  .reset       (reset),
  .req_val     (req_val),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

// File: dv/imuldiv_tb.sv
/*
 * testbench for the multiply/divide top level
 * lfsr stimulus with back-pressure, reference model, in-order response checker
 */

`timescale 1ns/1ps

module imuldiv_tb import imuldiv_pkg::*; ();

  localparam int W          = 32;
  localparam int CLK_PERIOD = 8;
  localparam int N_CORNER   = 8;
  localparam int N_RANDOM   = 256;
  localparam int N_OPS      = N_CORNER * N_CORNER * 3 + N_RANDOM;

  logic           clk;
  logic           reset;
  logic [W-1:0]   req_a;
  logic [W-1:0]   req_b;
  imuldiv_fn_e    req_fn;
  logic           req_val;
  logic           req_rdy;
  logic [2*W-1:0] resp_result;
  logic           resp_val;
  logic           resp_rdy;

  logic [31:0]    lfsr;

  // expected results in request order
  logic [2*W-1:0] exp_q[$];
  logic [W-1:0]   a_q[$];
  logic [W-1:0]   b_q[$];
  imuldiv_fn_e    fn_q[$];

  int req_count    = 0;
  int resp_count   = 0;
  int check_errors = 0;
  int other_errors = 0;

  imuldiv_top #(.W(W)) DUT (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_fn      (req_fn),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------------------------
  // random source and reference model
  // ----------------------------------------------------------

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic logic [W-1:0] corner_value(input int idx);
    case (idx)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hffff_ffff;
      3:       return 32'h8000_0000;
      4:       return 32'h7fff_ffff;
      5:       return 32'h0000_0003;
      6:       return 32'hffff_fffd;
      default: return 32'h8000_0001;
    endcase
  endfunction

  // mostly random words, with corners mixed in
  function automatic logic [W-1:0] random_operand();
    logic [31:0] bits;
    bits = draw_bits(3);
    if (bits < 32'd3) begin
      bits = draw_bits(3);
      return corner_value(int'(bits));
    end
    return draw_bits(W);
  endfunction

  function automatic logic [2*W-1:0] ref_muldiv(input logic [W-1:0] a, input logic [W-1:0] b,
                                                input imuldiv_fn_e fn);
    logic signed [2*W-1:0] sa;
    logic signed [2*W-1:0] sb;
    logic                  neg_a;
    logic                  neg_b;
    logic [W-1:0]          ma;
    logic [W-1:0]          mb;
    logic [W-1:0]          q;
    logic [W-1:0]          r;
    sa = {{W{a[W-1]}}, a};
    sb = {{W{b[W-1]}}, b};
    if (fn == fn_mul) begin
      return sa * sb;
    end
    // divu sees the operands as unsigned
    neg_a = (fn == fn_div) && a[W-1];
    neg_b = (fn == fn_div) && b[W-1];
    ma = neg_a ? -a : a;
    mb = neg_b ? -b : b;
    if (mb == '0) begin
      q = '1;
      r = ma;
    end else begin
      q = ma / mb;
      r = ma % mb;
    end
    if (neg_a ^ neg_b) begin
      q = -q;
    end
    if (neg_a) begin
      r = -r;
    end
    return {r, q};
  endfunction

  // ----------------------------------------------------------
  // stimulus, all inputs change on the falling edge
  // ----------------------------------------------------------

  task automatic drive_resp_rdy();
    logic [31:0] bits;
    bits = draw_bits(1);
    resp_rdy = bits[0];
  endtask

  // random idle gap, then hold the request until req_rdy
  task automatic send_request(input logic [W-1:0] a, input logic [W-1:0] b,
                              input imuldiv_fn_e fn);
    logic [31:0] gap;
    logic        took;
    gap = draw_bits(2);
    repeat (gap[1:0]) begin
      @(negedge clk);
      req_val = 1'b0;
      drive_resp_rdy();
    end
    @(negedge clk);
    req_a   = a;
    req_b   = b;
    req_fn  = fn;
    req_val = 1'b1;
    drive_resp_rdy();
    #1;
    took = req_rdy;
    while (!took) begin
      @(negedge clk);
      drive_resp_rdy();
      #1;
      took = req_rdy;
    end
  endtask

  initial begin
    logic [31:0]  bits;
    logic [W-1:0] ra;
    logic [W-1:0] rb;
    lfsr     = 32'd64;
    reset    = 1'b1;
    req_a    = '0;
    req_b    = '0;
    req_fn   = fn_mul;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    #1;
    if (req_rdy !== 1'b1 || resp_val !== 1'b0) begin
      $display("CHECK FAILED t=%0t: after reset req_rdy=%b resp_val=%b", $time, req_rdy,
               resp_val);
      check_errors++;
    end
    // every corner pair under every function code
    for (int i = 0; i < N_CORNER; i++) begin
      for (int j = 0; j < N_CORNER; j++) begin
        for (int f = 0; f < 3; f++) begin
          send_request(corner_value(i), corner_value(j), imuldiv_fn_e'(f[1:0]));
        end
      end
    end
    for (int n = 0; n < N_RANDOM; n++) begin
      ra   = random_operand();
      rb   = random_operand();
      bits = draw_bits(2);
      send_request(ra, rb, (bits[1:0] == 2'd3) ? fn_mul : imuldiv_fn_e'(bits[1:0]));
    end
    // drain the last response under back-pressure
    while (resp_count < N_OPS) begin
      @(negedge clk);
      req_val = 1'b0;
      drive_resp_rdy();
    end
    repeat (4) @(negedge clk);
    if (req_count != N_OPS || resp_count != req_count || exp_q.size() != 0) begin
      $display("request and response counts do not match: %0d sent, %0d returned",
               req_count, resp_count);
      other_errors++;
    end
    $display("requests %0d, responses %0d, check errors %0d, other errors %0d",
             req_count, resp_count, check_errors, other_errors);
    if (check_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // ----------------------------------------------------------
  // monitor and comparator, sampled mid-cycle
  // ----------------------------------------------------------

  initial begin
    logic [2*W-1:0] expected;
    logic [W-1:0]   ea;
    logic [W-1:0]   eb;
    imuldiv_fn_e    efn;
    forever begin
      @(negedge clk);
      #2;
      if (!reset && req_val && req_rdy) begin
        exp_q.push_back(ref_muldiv(req_a, req_b, req_fn));
        a_q.push_back(req_a);
        b_q.push_back(req_b);
        fn_q.push_back(req_fn);
        req_count++;
      end
      if (!reset && resp_val && resp_rdy) begin
        resp_count++;
        if (exp_q.size() == 0) begin
          $display("response at %0t arrived with no request outstanding", $time);
          other_errors++;
        end else begin
          expected = exp_q.pop_front();
          ea       = a_q.pop_front();
          eb       = b_q.pop_front();
          efn      = fn_q.pop_front();
          if (resp_result !== expected) begin
            $display("CHECK FAILED t=%0t: fn %0d a=%h b=%h result %h expected %h", $time,
                     efn, ea, eb, resp_result, expected);
            check_errors++;
          end
        end
      end
    end
  end

  // about 80 cycles per operation covers gaps and stalls
  initial begin
    #(N_OPS * 80 * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", N_OPS * 80);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: imuldiv.f
logic/imuldiv_pkg.sv
logic/imuldiv_iter_if.sv
logic/imuldiv_mul_iterative.sv
logic/imuldiv_div_iterative.sv
logic/imuldiv_dispatch.sv
logic/imuldiv_top.sv
dv/imuldiv_asserts.sv
dv/imuldiv_tb.sv

// File: Makefile
TOP := imuldiv_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f imuldiv.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
